// ==== attitude_pkg.sv ====
package attitude_pkg;

    // ==================================================
    // Frame layout
    // ==================================================

    // Header, six samples, flags and two spare bytes
    localparam int FRAME_BYTES = 16;

    // The master opens every frame with this byte
    localparam logic [7:0] HEADER_BYTE = 8'hAA;

    // Bit positions inside the flags byte
    // Bit 0 qualifies roll, pitch and yaw, bit 1 qualifies the three gyro words
    localparam int FLAG_EULER_BIT = 0;
    localparam int FLAG_GYRO_BIT  = 1;

    // ==================================================
    // Frame types
    // ==================================================

    // One signed measurement word, sent high byte first
    typedef logic signed [15:0] sample_t;

    // Members are listed in wire order
    // The header arrives first and so sits in the most significant byte
    typedef struct packed {
        logic [7:0]  header;
        sample_t     roll;
        sample_t     pitch;
        sample_t     yaw;
        sample_t     gyro_x;
        sample_t     gyro_y;
        sample_t     gyro_z;
        logic [7:0]  flags;
        logic [15:0] reserved;
    } frame_fields_t;

    // The same 128 bits seen two ways
    // The receiver writes whole bytes by arrival index, with index 0 at the top
    // The decoder reads named fields from the very same bits
    typedef union packed {
        logic [0:FRAME_BYTES-1][7:0] bytes;
        frame_fields_t               fields;
    } frame_u;

endpackage

// ==== spi_frame_rx.sv ====
`timescale 1ns/1ps

module spi_frame_rx (
    input  logic                 sck,
    input  logic                 cs_n,
    input  logic                 sdi,
    output attitude_pkg::frame_u rx_frame
);

    import attitude_pkg::*;

    // Byte pointer wide enough to address every byte of the frame
    localparam int IDX_W = $clog2(FRAME_BYTES);

    // ==================================================
    // Bit and byte tracking in the sck domain
    // ==================================================

    // Only seven bits are kept because the eighth goes straight to the buffer
    logic [6:0]       shift_q;
    logic [2:0]       bit_cnt;
    logic [IDX_W-1:0] byte_idx;

    // Byte as it would look with the current sdi bit as its LSB
    logic [7:0] rx_byte;
    logic       byte_done;

    assign rx_byte   = {shift_q, sdi};
    assign byte_done = (bit_cnt == 3'd7);

    // Mode 0 puts the data on the line before the rising edge, so sample there
    // A deselect restarts the byte framing at once, even with sck idle
    always_ff @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            shift_q  <= '0;
            bit_cnt  <= '0;
            byte_idx <= '0;
        end else begin
            shift_q <= rx_byte[6:0];
            // The 3-bit counter rolls from 7 back to 0 on its own
            bit_cnt <= bit_cnt + 3'd1;
            if (byte_done) begin
                // Index 15 rolls over to 0, so an overlong frame wraps
                byte_idx <= byte_idx + IDX_W'(1);
            end
        end
    end

    // ==================================================
    // Frame buffer
    // ==================================================

    // The buffer keeps its content across the deselect
    // The clk domain copies it out while cs_n is high and sck is idle
    always_ff @(posedge sck) begin
        if (!cs_n && byte_done) begin
            rx_frame.bytes[byte_idx] <= rx_byte;
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // Stray sck edges while deselected must leave the byte pointer alone
    // Otherwise the next frame would start in the middle of the buffer
    property p_idx_frozen_when_deselected;
        @(posedge sck) (cs_n && $past(cs_n)) |-> $stable(byte_idx);
    endproperty

    a_idx_frozen_when_deselected : assert property (p_idx_frozen_when_deselected)
        else $error("spi_frame_rx: byte index moved while cs_n was high");

endmodule

// ==== frame_capture.sv ====
`timescale 1ns/1ps

module frame_capture #(
    parameter int SETTLE_CYCLES = 3
) (
    input  logic                 clk,
    input  logic                 cs_n,
    input  attitude_pkg::frame_u rx_frame,
    output attitude_pkg::frame_u cap_frame,
    output logic                 cap_strobe
);

    import attitude_pkg::*;

    // One extra count value keeps the width valid for SETTLE_CYCLES of 1
    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    // ==================================================
    // Chip select synchronizer
    // ==================================================

    // All clk-domain state powers up at zero
    // A cs_n that is already high at power-up then looks like a rise, not a fall
    logic cs_meta   = 1'b0;
    logic cs_sync   = 1'b0;
    logic cs_sync_d = 1'b0;
    logic cs_fall;

    always_ff @(posedge clk) begin
        cs_meta   <= cs_n;
        cs_sync   <= cs_meta;
        cs_sync_d <= cs_sync;
    end

    // A synchronized fall marks the start of a real transaction
    assign cs_fall = cs_sync_d && !cs_sync;

    // ==================================================
    // Settle counter and arm flag
    // ==================================================

    logic [CNT_W-1:0] settle_cnt = '0;
    logic             settled;
    logic             armed      = 1'b0;
    logic             capture;

    // The count holds how many earlier cycles saw cs_sync high
    // The current high cycle completes the window, so compare with one less
    assign settled = cs_sync && (settle_cnt == CNT_W'(SETTLE_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!cs_sync) begin
            settle_cnt <= '0;
        end else if (!settled) begin
            settle_cnt <= settle_cnt + CNT_W'(1);
        end
    end

    // Take one snapshot per transaction and none at power-up
    assign capture = settled && armed;

    // Capture and a fall never coincide, since one needs cs_sync high and one low
    always_ff @(posedge clk) begin
        if (capture) begin
            armed <= 1'b0;
        end else if (cs_fall) begin
            armed <= 1'b1;
        end
    end

    // ==================================================
    // Snapshot register
    // ==================================================

    frame_u cap_q    = '0;
    logic   strobe_q = 1'b0;

    // The sck-domain buffer is static here
    // cs_n has been high for the settle window and Mode 0 keeps sck low when idle
    // All 128 bits are therefore copied in one cycle with no per-bit sync
    always_ff @(posedge clk) begin
        if (capture) begin
            cap_q <= rx_frame;
        end
    end

    // The strobe rises on the same edge that loads the snapshot
    always_ff @(posedge clk) begin
        strobe_q <= capture;
    end

    assign cap_frame  = cap_q;
    assign cap_strobe = strobe_q;

    // ==================================================
    // Checks
    // ==================================================

    // Disarming on capture makes the strobe a single-cycle pulse
    a_strobe_single : assert property (@(posedge clk) cap_strobe |=> !cap_strobe)
        else $error("frame_capture: cap_strobe high on two consecutive cycles");

    // The decoder relies on the snapshot changing only together with the strobe
    a_frame_with_strobe : assert property (
        @(posedge clk) !$stable(cap_frame) |-> $rose(cap_strobe)
    ) else $error("frame_capture: cap_frame changed without a strobe");

endmodule

// ==== frame_decoder.sv ====
`timescale 1ns/1ps

module frame_decoder (
    input  logic                   clk,
    input  attitude_pkg::frame_u   cap_frame,
    input  logic                   cap_strobe,
    output logic                   initialized,
    output logic                   error,
    output logic                   euler_valid,
    output logic                   gyro_valid,
    output attitude_pkg::sample_t  roll,
    output attitude_pkg::sample_t  pitch,
    output attitude_pkg::sample_t  yaw,
    output attitude_pkg::sample_t  gyro_x,
    output attitude_pkg::sample_t  gyro_y,
    output attitude_pkg::sample_t  gyro_z
);

    import attitude_pkg::*;

    // ==================================================
    // Header check
    // ==================================================

    logic header_ok;

    // The snapshot holds still between strobes, so a plain compare is enough
    assign header_ok = (cap_frame.fields.header == HEADER_BYTE);

    // ==================================================
    // Status bits
    // ==================================================

    // Both start low, so nothing is reported before the first frame
    logic init_q = 1'b0;
    logic err_q  = 1'b0;

    // Every captured frame decides both bits, and they always end up opposite
    always_ff @(posedge clk) begin
        if (cap_strobe) begin
            init_q <= header_ok;
            err_q  <= !header_ok;
        end
    end

    // ==================================================
    // Data and valid registers
    // ==================================================

    sample_t roll_q   = '0;
    sample_t pitch_q  = '0;
    sample_t yaw_q    = '0;
    sample_t gyro_x_q = '0;
    sample_t gyro_y_q = '0;
    sample_t gyro_z_q = '0;
    logic    euler_q  = 1'b0;
    logic    gyro_q   = 1'b0;

    // A bad frame leaves the last good values in place
    // The reserved bytes are never looked at
    always_ff @(posedge clk) begin
        if (cap_strobe && header_ok) begin
            roll_q   <= cap_frame.fields.roll;
            pitch_q  <= cap_frame.fields.pitch;
            yaw_q    <= cap_frame.fields.yaw;
            gyro_x_q <= cap_frame.fields.gyro_x;
            gyro_y_q <= cap_frame.fields.gyro_y;
            gyro_z_q <= cap_frame.fields.gyro_z;
            euler_q  <= cap_frame.fields.flags[FLAG_EULER_BIT];
            gyro_q   <= cap_frame.fields.flags[FLAG_GYRO_BIT];
        end
    end

    assign initialized = init_q;
    assign error       = err_q;
    assign euler_valid = euler_q;
    assign gyro_valid  = gyro_q;
    assign roll        = roll_q;
    assign pitch       = pitch_q;
    assign yaw         = yaw_q;
    assign gyro_x      = gyro_x_q;
    assign gyro_y      = gyro_y_q;
    assign gyro_z      = gyro_z_q;

    // ==================================================
    // Checks
    // ==================================================

    // A consumer must never see a link that is both up and failed
    a_status_exclusive : assert property (@(posedge clk) !(initialized && error))
        else $error("frame_decoder: initialized and error both high");

endmodule

// ==== imu_spi_link.sv ====
`timescale 1ns/1ps

module imu_spi_link #(
    // Clk cycles that synchronized cs_n must stay high before a capture
    parameter int SETTLE_CYCLES = 3
) (
    input  logic               clk,
    input  logic               cs_n,
    input  logic               sck,
    input  logic               sdi,
    output logic               initialized,
    output logic               error,
    output logic               euler_valid,
    output logic               gyro_valid,
    output logic signed [15:0] roll,
    output logic signed [15:0] pitch,
    output logic signed [15:0] yaw,
    output logic signed [15:0] gyro_x,
    output logic signed [15:0] gyro_y,
    output logic signed [15:0] gyro_z
);

    import attitude_pkg::*;

    // ==================================================
    // Internal links
    // ==================================================

    // Receive buffer, living in the sck domain
    frame_u rx_frame;

    // Snapshot and its strobe, both in the clk domain
    frame_u cap_frame;
    logic   cap_strobe;

    // Shifts the frame in on sck and holds it after the deselect
    spi_frame_rx spi_frame_rx_i (
        .sck      (sck),
        .cs_n     (cs_n),
        .sdi      (sdi),
        .rx_frame (rx_frame)
    );

    // Moves the finished frame into the clk domain once cs_n has settled
    frame_capture #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) frame_capture_i (
        .clk        (clk),
        .cs_n       (cs_n),
        .rx_frame   (rx_frame),
        .cap_frame  (cap_frame),
        .cap_strobe (cap_strobe)
    );

    // Checks the header and publishes the words one cycle after the strobe
    frame_decoder frame_decoder_i (
        .clk         (clk),
        .cap_frame   (cap_frame),
        .cap_strobe  (cap_strobe),
        .initialized (initialized),
        .error       (error),
        .euler_valid (euler_valid),
        .gyro_valid  (gyro_valid),
        .roll        (roll),
        .pitch       (pitch),
        .yaw         (yaw),
        .gyro_x      (gyro_x),
        .gyro_y      (gyro_y),
        .gyro_z      (gyro_z)
    );

endmodule

// ==== tb_imu_spi_link.sv ====
`timescale 1ns/1ps

module tb_imu_spi_link;

    import attitude_pkg::*;

    // ==================================================
    // Test parameters
    // ==================================================

    localparam int SETTLE    = 3;
    // Shortest cs_n high time that still lets the snapshot happen
    localparam int MIN_GAP   = SETTLE + 3;
    // Gap used by the ordinary tests, well above the minimum
    localparam int GAP       = 20;
    // Each bit takes two clk cycles low and two high
    localparam int FRAME_CYC = FRAME_BYTES * 8 * 4 + GAP;
    // Frames sent over all tests together
    localparam int N_FRAMES  = 8;
    // Twice the length of the whole run leaves ample margin
    localparam int TIMEOUT_CYCLES = 2 * N_FRAMES * FRAME_CYC;

    // ==================================================
    // DUT signals
    // ==================================================

    logic    clk;
    logic    cs_n;
    logic    sck;
    logic    sdi;
    logic    initialized;
    logic    error;
    logic    euler_valid;
    logic    gyro_valid;
    sample_t roll;
    sample_t pitch;
    sample_t yaw;
    sample_t gyro_x;
    sample_t gyro_y;
    sample_t gyro_z;

    imu_spi_link #(
        .SETTLE_CYCLES (SETTLE)
    ) imu_spi_link_i (
        .clk         (clk),
        .cs_n        (cs_n),
        .sck         (sck),
        .sdi         (sdi),
        .initialized (initialized),
        .error       (error),
        .euler_valid (euler_valid),
        .gyro_valid  (gyro_valid),
        .roll        (roll),
        .pitch       (pitch),
        .yaw         (yaw),
        .gyro_x      (gyro_x),
        .gyro_y      (gyro_y),
        .gyro_z      (gyro_z)
    );

    // ==================================================
    // Clock, timeout and bookkeeping
    // ==================================================

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    int          cycle_cnt   = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;
    logic [31:0] rng_state   = 32'h2019;

    // Expected output state, built from the decoder rule alone
    frame_u last_good = '0;
    logic   exp_init  = 1'b0;
    logic   exp_err   = 1'b0;

    // A stuck handshake or a runaway loop ends here
    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d clk cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // ==================================================
    // Helpers
    // ==================================================

    // Plain 32-bit xorshift, good enough for sample words
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic sample_t random_sample();
        rng_state = xorshift32(rng_state);
        return sample_t'(rng_state[15:0]);
    endfunction

    // Fills all words with fresh random values, the reserved bytes too
    function automatic frame_u make_frame(input logic [7:0] header, input logic [7:0] flags);
        frame_u f;
        f.fields.header   = header;
        f.fields.roll     = random_sample();
        f.fields.pitch    = random_sample();
        f.fields.yaw      = random_sample();
        f.fields.gyro_x   = random_sample();
        f.fields.gyro_y   = random_sample();
        f.fields.gyro_z   = random_sample();
        f.fields.flags    = flags;
        f.fields.reserved = random_sample();
        return f;
    endfunction

    // Mode 0 master: data set while sck is low, sampled by the slave on the rise
    // Called right after a falling clk edge and returns right after one
    task automatic send_frame(input frame_u f, input int gap);
        cs_n = 1'b0;
        sck  = 1'b0;
        for (int b = 0; b < FRAME_BYTES; b++) begin
            for (int k = 7; k >= 0; k--) begin
                sdi = f.bytes[b][k];
                repeat (2) @(negedge clk);
                sck = 1'b1;
                repeat (2) @(negedge clk);
                sck = 1'b0;
            end
        end
        cs_n = 1'b1;
        sdi  = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // A good header replaces all data, a bad one only flips the status bits
    task automatic apply_decode_rule(input frame_u sent);
        if (sent.fields.header == HEADER_BYTE) begin
            last_good = sent;
            exp_init  = 1'b1;
            exp_err   = 1'b0;
        end else begin
            exp_init = 1'b0;
            exp_err  = 1'b1;
        end
    endtask

    task automatic compare_sample(input string name, input sample_t exp, input sample_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // Compares every DUT output with the model
    task automatic check_outputs();
        compare_bit("initialized", exp_init, initialized);
        compare_bit("error", exp_err, error);
        compare_bit("euler_valid", last_good.fields.flags[FLAG_EULER_BIT], euler_valid);
        compare_bit("gyro_valid", last_good.fields.flags[FLAG_GYRO_BIT], gyro_valid);
        compare_sample("roll", last_good.fields.roll, roll);
        compare_sample("pitch", last_good.fields.pitch, pitch);
        compare_sample("yaw", last_good.fields.yaw, yaw);
        compare_sample("gyro_x", last_good.fields.gyro_x, gyro_x);
        compare_sample("gyro_y", last_good.fields.gyro_y, gyro_y);
        compare_sample("gyro_z", last_good.fields.gyro_z, gyro_z);
    endtask

    // Sends one frame, updates the model and checks the outputs
    task automatic run_frame(input logic [7:0] header, input logic [7:0] flags, input int gap);
        frame_u f;
        f = make_frame(header, flags);
        send_frame(f, gap);
        apply_decode_rule(f);
        check_outputs();
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("%s: done, %0d errors", name, error_count - errs_before);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    // Nothing may be reported before the first transaction
    task automatic test_after_reset();
        int errs;
        errs = error_count;
        check_outputs();
        report_test("test_after_reset", errs);
    endtask

    task automatic test_good_frame();
        int errs;
        errs = error_count;
        run_frame(HEADER_BYTE, 8'h03, GAP);
        report_test("test_good_frame", errs);
    endtask

    // Each flag bit drives its own valid output
    task automatic test_flag_variants();
        int errs;
        errs = error_count;
        run_frame(HEADER_BYTE, 8'h01, GAP);
        run_frame(HEADER_BYTE, 8'h02, GAP);
        report_test("test_flag_variants", errs);
    endtask

    // Data and valid bits must hold the last good frame
    task automatic test_bad_header();
        int errs;
        errs = error_count;
        run_frame(8'h55, 8'h03, GAP);
        report_test("test_bad_header", errs);
    endtask

    task automatic test_recovery();
        int errs;
        errs = error_count;
        run_frame(HEADER_BYTE, 8'h03, GAP);
        report_test("test_recovery", errs);
    endtask

    // Each frame must be captured before the next one starts shifting in
    task automatic test_back_to_back();
        int errs;
        errs = error_count;
        for (int n = 0; n < 3; n++) begin
            run_frame(HEADER_BYTE, 8'h03, MIN_GAP);
        end
        report_test("test_back_to_back", errs);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        cs_n = 1'b1;
        sck  = 1'b0;
        sdi  = 1'b0;
        // Deselected for five cycles, which clears the sck-domain state
        repeat (5) @(negedge clk);

        test_after_reset();
        test_good_frame();
        test_flag_variants();
        test_bad_header();
        test_recovery();
        test_back_to_back();

        $display("Summary: %0d tests, %0d checks, %0d errors in %0d cycles",
                 test_count, check_count, error_count, cycle_cnt);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== imu_spi_link.f ====
attitude_pkg.sv
spi_frame_rx.sv
frame_capture.sv
frame_decoder.sv
imu_spi_link.sv
tb_imu_spi_link.sv

// ==== Bender.yml ====
# SPI slave receiver for an IMU attitude link
package:
  name: imu_spi_link

dependencies: {}

sources:
  # Shared frame types come first
  - attitude_pkg.sv
  # Receiver, clock domain capture and decoder
  - spi_frame_rx.sv
  - frame_capture.sv
  - frame_decoder.sv
  # Top level
  - imu_spi_link.sv
  # Directed testbench, only in simulation
  - target: test
    files:
      - tb_imu_spi_link.sv
